//--- all.f
rtl/nn_fixed_pkg.sv
rtl/nn_load_pkg.sv
rtl/layer_sequencer.sv
rtl/layer_feed.sv
rtl/neuron.sv
rtl/activation_collector.sv
rtl/nn_top.sv
dv/nn_top_tb.sv

//--- dv/nn_patterns.txt
// record: load count, load words {kind, data}, expected result[0..3], expected overflow
// weight word 0LNIVVVV (layer, neuron, index, value); sample word 1<<28 | index<<9 | act
4
// diagonal layer 0, identity layer 1
24
00000100 00010000 00020000 00030000 00100000 00110180 00120000 00130000
00200000 00210000 00220300 00230000 00300000 00310000 00320000 00330040
01000100 01010000 01020000 01030000 01100000 01110100 01120000 01130000
01200000 01210000 01220100 01230000 01300000 01310000 01320000 01330100
10000080 10000300 10000440 100007C0
080 180 0C0 070
0
// mixed weights over both layers
24
00000080 00010100 00020000 00030040 00100040 0011FF80 00120200 00130000
00200000 00210080 00220100 00230100 00300020 00310000 00320000 00330080
01000040 01010040 01020040 01030040 01100100 0111FF00 01120000 01130080
01200000 01210180 0122FFC0 01230000 01300080 01310000 01320080 0133FE00
10000100 10000280 10000440 100006C0
0DC 0F0 070 038
0
// neuron 2 goes negative, neuron 3 saturates
2
0122FE00 01300400
0DC 0F0 000 1FF
1
// new layer 1 weights for neuron 3 only
4
01300100 01310100 01320000 01330000
0DC 0F0 000 1B0
0

//--- dv/nn_top_tb.sv
`timescale 1ns/100ps

module nn_top_tb;

    import nn_fixed_pkg::*;
    import nn_load_pkg::*;

    localparam int NEURON_NUM    = 4;
    localparam int LAYER_MAX     = 2;
    localparam int LATENCY       = LAYER_MAX * (NEURON_NUM + 4);
    localparam int LOAD_MAX      = LAYER_MAX * NEURON_NUM * NEURON_NUM + NEURON_NUM;
    // loads, run, back-pressure and the watch for a second result
    localparam int TEST_CYCLES   = 2 * LATENCY + LOAD_MAX + 20;
    localparam int PATTERN_DEPTH = 256;
    localparam int KIND_BIT      = LOAD_WIDTH;

    logic                                        clk = 1'b0;
    logic                                        rst;
    logic                                        load_valid;
    load_kind_e                                  load_kind;
    logic [LOAD_WIDTH-1:0]                       load_data;
    logic                                        start;
    logic [NEURON_NUM-1:0][ACTIVATION_WIDTH-1:0] result;
    logic                                        result_valid;
    logic                                        result_ready;
    logic                                        overflow;

    logic [31:0] patterns [PATTERN_DEPTH];
    int          ptr;
    int          num_tests;
    int          error_count;
    int          failed_tests;
    int          cycle_count = 0;
    int          cycle_limit = TEST_CYCLES;
    integer      seed;

    nn_top #(
        .NEURON_NUM(NEURON_NUM),
        .LAYER_MAX (LAYER_MAX )
    ) UUT (
        .clk         (clk         ),
        .rst         (rst         ),
        .load_valid  (load_valid  ),
        .load_kind   (load_kind   ),
        .load_data   (load_data   ),
        .start       (start       ),
        .result      (result      ),
        .result_valid(result_valid),
        .result_ready(result_ready),
        .overflow    (overflow    )
    );

    always #2 clk = ~clk;

    // watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles", cycle_count);
            $display("Done: errors found");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic report_test(input int test_num, input int errors_before);
        if (error_count == errors_before) begin
            $display("test %0d passed", test_num);
        end else begin
            $display("test %0d failed with %0d errors", test_num,
                     error_count - errors_before);
            failed_tests++;
        end
    endtask

    // one word per cycle, kind bit sits above the load word
    task automatic drive_load(input logic [31:0] word);
        @(posedge clk);
        load_valid <= 1'b1;
        load_kind  <= load_kind_e'(word[KIND_BIT]);
        load_data  <= word[LOAD_WIDTH-1:0];
    endtask

    // no start given, nothing may come out
    task automatic check_idle(input int cycles);
        int errors_before;

        errors_before = error_count;
        for (int c = 0; c < cycles; c++) begin
            @(posedge clk);
            if (result_valid !== 1'b0) begin
                $display("Error: result_valid = 0x%h, expected 0x0", result_valid);
                error_count++;
            end
            if (overflow !== 1'b0) begin
                $display("Error: overflow = 0x%h, expected 0x0", overflow);
                error_count++;
            end
        end
        report_test(0, errors_before);
    endtask

    task automatic run_test(input int test_num);
        int                                          n_loads;
        int                                          waited;
        int                                          hold;
        int                                          errors_before;
        int                                          second_results;
        logic [NEURON_NUM-1:0][ACTIVATION_WIDTH-1:0] expected;
        logic [NEURON_NUM-1:0][ACTIVATION_WIDTH-1:0] held;
        logic                                        expected_ovf;

        errors_before = error_count;
        n_loads = patterns[ptr];
        ptr++;
        for (int i = 0; i < n_loads; i++) begin
            drive_load(patterns[ptr]);
            ptr++;
        end
        for (int n = 0; n < NEURON_NUM; n++) begin
            expected[n] = patterns[ptr][ACTIVATION_WIDTH-1:0];
            ptr++;
        end
        expected_ovf = patterns[ptr][0];
        ptr++;

        // start right after the last load
        @(posedge clk);
        load_valid <= 1'b0;
        start      <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        waited = 0;
        while (result_valid !== 1'b1 && waited <= LATENCY + 2) begin
            @(posedge clk);
            waited++;
        end

        if (result_valid !== 1'b1) begin
            $display("test %0d: result_valid did not rise within %0d cycles of start",
                     test_num, LATENCY + 2);
            error_count++;
        end else begin
            for (int n = 0; n < NEURON_NUM; n++) begin
                if (result[n] !== expected[n]) begin
                    $display("Error: result[%0d] = 0x%h, expected 0x%h", n, result[n],
                             expected[n]);
                    error_count++;
                end
            end
            if (overflow !== expected_ovf) begin
                $display("Error: overflow = 0x%h, expected 0x%h", overflow, expected_ovf);
                error_count++;
            end

            // back-pressure with a second start that must be dropped
            held = result;
            hold = 2 + ($unsigned($random(seed)) % 6);
            for (int c = 0; c < hold; c++) begin
                @(posedge clk);
                start <= (c == 0);
                if (result_valid !== 1'b1) begin
                    $display("Error: result_valid = 0x%h, expected 0x1", result_valid);
                    error_count++;
                end
                if (result !== held) begin
                    $display("Error: result = 0x%h, expected 0x%h", result, held);
                    error_count++;
                end
            end
            @(posedge clk);
            result_ready <= 1'b1;
            @(posedge clk);
            result_ready <= 1'b0;

            // long enough for a wrongly accepted run to finish
            second_results = 0;
            for (int c = 0; c < LATENCY + 2; c++) begin
                @(posedge clk);
                if (result_valid !== 1'b0) begin
                    second_results++;
                end
            end
            if (second_results != 0) begin
                $display("test %0d: result_valid was high again after the result was taken",
                         test_num);
                error_count++;
            end
        end
        report_test(test_num, errors_before);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        seed         = 12578;
        error_count  = 0;
        failed_tests = 0;
        rst          = 1'b1;
        load_valid   = 1'b0;
        load_kind    = LOAD_WEIGHT;
        load_data    = '0;
        start        = 1'b0;
        result_ready = 1'b0;

        $readmemh("dv/nn_patterns.txt", patterns);
        if ($isunknown(patterns[0]) || patterns[0] == 0) begin
            $display("pattern file dv/nn_patterns.txt is missing or holds no tests");
            error_count++;
            num_tests = 0;
        end else begin
            num_tests = patterns[0];
        end
        ptr = 1;
        // one extra test length covers reset and the idle check
        cycle_limit = (num_tests + 1) * TEST_CYCLES;

        repeat (4) @(posedge clk);
        rst <= 1'b0;

        check_idle(2 * NEURON_NUM);
        for (int t = 1; t <= num_tests; t++) begin
            run_test(t);
        end

        $display("%0d tests, %0d failed, %0d errors", num_tests + 1, failed_tests,
                 error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- rtl/activation_collector.sv
`timescale 1ns/100ps

module activation_collector #(
    parameter int NEURON_NUM = 4
) (
    input  logic                                                  clk,
    input  logic                                                  rst,
    input  logic [NEURON_NUM-1:0][nn_fixed_pkg::ACTIVATION_WIDTH-1:0] out_act,
    input  logic [NEURON_NUM-1:0]                                 out_valid,
    input  logic [NEURON_NUM-1:0]                                 out_sat,
    input  logic                                                  run_start,
    output logic [NEURON_NUM-1:0][nn_fixed_pkg::ACTIVATION_WIDTH-1:0] layer_vector,
    output logic                                                  layer_done,
    output logic                                                  overflow
);

    logic layer_ready;

    // neurons run in lockstep, all valid in one cycle
    assign layer_ready = &out_valid;

    // layer result, held until the next layer ends
    always_ff @(posedge clk) begin
        if (layer_ready) begin
            layer_vector <= out_act;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            layer_done <= 1'b0;
            overflow   <= 1'b0;
        end else begin
            layer_done <= layer_ready;
            // sticky over the whole run
            if (run_start) begin
                overflow <= 1'b0;
            end else if (layer_ready && |out_sat) begin
                overflow <= 1'b1;
            end
        end
    end

endmodule

//--- rtl/layer_feed.sv
`timescale 1ns/100ps

module layer_feed #(
    parameter int NEURON_NUM = 4
) (
    input  logic                                                  clk,
    input  logic                                                  rst,
    input  logic                                                  load_valid,
    input  nn_load_pkg::load_kind_e                               load_kind,
    input  nn_load_pkg::load_word_u                               load_data,
    input  logic [nn_load_pkg::LAYER_FIELD-1:0]                   layer,
    input  logic                                                  layer_go,
    input  logic [NEURON_NUM-1:0][nn_fixed_pkg::ACTIVATION_WIDTH-1:0] layer_vector,
    output logic [nn_fixed_pkg::ACTIVATION_WIDTH-1:0]             feed_act,
    output logic [nn_load_pkg::NEURON_FIELD-1:0]                  feed_index,
    output logic                                                  feed_valid,
    output logic                                                  feed_last
);

    import nn_fixed_pkg::*;
    import nn_load_pkg::*;

    logic [NEURON_NUM-1:0][ACTIVATION_WIDTH-1:0] sample_vec;
    logic [NEURON_NUM-1:0][ACTIVATION_WIDTH-1:0] stream_vec;
    logic [NEURON_FIELD-1:0]                     count;
    logic                                        streaming;
    logic                                        sample_wr;
    logic                                        count_last;

    assign sample_wr = load_valid && (load_kind == LOAD_SAMPLE) &&
                       (load_data.sample.index < NEURON_NUM);

    assign count_last = (count == NEURON_FIELD'(NEURON_NUM - 1));

    // input sample, written by the host between runs
    always_ff @(posedge clk) begin
        if (sample_wr) begin
            sample_vec[load_data.sample.index] <= load_data.sample.activation;
        end
    end

    // layer 0 reads the sample, later layers the previous result
    always_ff @(posedge clk) begin
        if (layer_go) begin
            stream_vec <= (layer == '0) ? sample_vec : layer_vector;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // element stream, one per cycle
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            streaming  <= 1'b0;
            count      <= '0;
            feed_valid <= 1'b0;
            feed_last  <= 1'b0;
        end else begin
            feed_valid <= streaming;
            feed_last  <= streaming && count_last;
            if (layer_go) begin
                streaming <= 1'b1;
                count     <= '0;
            end else if (streaming) begin
                count <= count + 1'b1;
                if (count_last) begin
                    streaming <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (streaming) begin
            feed_act   <= stream_vec[count];
            feed_index <= count;
        end
    end

endmodule

//--- rtl/layer_sequencer.sv
`timescale 1ns/100ps

module layer_sequencer #(
    parameter int LAYER_MAX = 2
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               start,
    input  logic                               layer_done,
    input  logic                               result_ready,
    output logic [nn_load_pkg::LAYER_FIELD-1:0] layer,
    output logic                               layer_go,
    output logic                               run_start,
    output logic                               result_valid
);

    import nn_load_pkg::*;

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_GO   = 2'd1;
    localparam logic [1:0] ST_WAIT = 2'd2;
    localparam logic [1:0] ST_DONE = 2'd3;

    logic [1:0] state;
    logic       last_layer;

    // only place that knows the network depth
    assign last_layer = (layer == LAYER_FIELD'(LAYER_MAX - 1));

    // moore outputs
    assign layer_go     = (state == ST_GO);
    assign result_valid = (state == ST_DONE);

    ////////////////////////////////////////////////////////////////////////////
    // run FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            layer     <= '0;
            run_start <= 1'b0;
        end else begin
            run_start <= 1'b0;
            case (state)
                ST_IDLE: begin
                    // start only counts here, busy or pending result drops it
                    if (start) begin
                        state     <= ST_GO;
                        layer     <= '0;
                        run_start <= 1'b1;
                    end
                end
                ST_GO: begin
                    state <= ST_WAIT;
                end
                ST_WAIT: begin
                    if (layer_done) begin
                        if (last_layer) begin
                            state <= ST_DONE;
                        end else begin
                            layer <= layer + 1'b1;
                            state <= ST_GO;
                        end
                    end
                end
                ST_DONE: begin
                    // hold result until the host takes it
                    if (result_ready) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

//--- rtl/neuron.sv
`timescale 1ns/100ps

module neuron #(
    parameter int NEURON_NUM   = 4,
    parameter int LAYER_MAX    = 2,
    parameter int NEURON_INDEX = 0
) (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      load_valid,
    input  nn_load_pkg::load_kind_e                   load_kind,
    input  nn_load_pkg::load_word_u                   load_data,
    input  logic [nn_load_pkg::LAYER_FIELD-1:0]       layer,
    input  logic                                      layer_go,
    input  logic [nn_fixed_pkg::ACTIVATION_WIDTH-1:0] feed_act,
    input  logic [nn_load_pkg::NEURON_FIELD-1:0]      feed_index,
    input  logic                                      feed_valid,
    input  logic                                      feed_last,
    output logic [nn_fixed_pkg::ACTIVATION_WIDTH-1:0] out_act,
    output logic                                      out_valid,
    output logic                                      out_sat
);

    import nn_fixed_pkg::*;
    import nn_load_pkg::*;

    localparam int DEPTH      = LAYER_MAX * NEURON_NUM;
    localparam int ADDR_WIDTH = $clog2(DEPTH);

    logic signed [WEIGHT_WIDTH-1:0] weight_mem [DEPTH];
    logic signed [WEIGHT_WIDTH-1:0] weight;
    logic [ADDR_WIDTH-1:0]          wr_addr;
    logic [ADDR_WIDTH-1:0]          rd_addr;
    logic                           wr_en;
    logic signed [ACC_WIDTH-1:0]    product;
    logic signed [ACC_WIDTH-1:0]    acc;
    logic signed [ACC_WIDTH-1:0]    shifted;
    logic                           negative;
    logic                           too_big;

    ////////////////////////////////////////////////////////////////////////////
    // weight memory, one row of NEURON_NUM weights per layer
    ////////////////////////////////////////////////////////////////////////////

    assign wr_en = load_valid && (load_kind == LOAD_WEIGHT) &&
                   (load_data.weight.neuron == NEURON_FIELD'(NEURON_INDEX)) &&
                   (load_data.weight.layer < LAYER_MAX) &&
                   (load_data.weight.index < NEURON_NUM);

    assign wr_addr = ADDR_WIDTH'(load_data.weight.layer * NEURON_NUM + load_data.weight.index);
    assign rd_addr = ADDR_WIDTH'(layer * NEURON_NUM + feed_index);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            weight_mem[wr_addr] <= load_data.weight.value;
        end
    end

    assign weight = weight_mem[rd_addr];

    // activation is unsigned, extend by a zero before the signed multiply
    assign product = $signed({1'b0, feed_act}) * weight;

    always_ff @(posedge clk) begin
        if (layer_go) begin
            acc <= '0;
        end else if (feed_valid) begin
            acc <= acc + product;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= feed_valid && feed_last;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // rescale, ReLU, clip
    ////////////////////////////////////////////////////////////////////////////

    assign shifted  = acc >>> FRACTION;
    assign negative = shifted[ACC_WIDTH-1];
    assign too_big  = |shifted[ACC_WIDTH-2:ACTIVATION_WIDTH];

    always_comb begin
        if (negative) begin
            out_act = '0;
        end else if (too_big) begin
            out_act = ACT_MAX;
        end else begin
            out_act = shifted[ACTIVATION_WIDTH-1:0];
        end
    end

    // negative sums are not saturation
    assign out_sat = !negative && too_big;

endmodule

//--- rtl/nn_fixed_pkg.sv
package nn_fixed_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // fixed point formats
    ////////////////////////////////////////////////////////////////////////////

    // unsigned activation, value range [0, 2)
    localparam int ACTIVATION_WIDTH = 9;

    // signed weight, same binary point as the activation
    localparam int WEIGHT_WIDTH = 16;

    // fraction bits of both formats
    localparam int FRACTION = 8;

    // signed accumulator
    // wide enough for a full dot product of 16 terms
    localparam int ACC_WIDTH = 32;

    ////////////////////////////////////////////////////////////////////////////
    // saturation
    ////////////////////////////////////////////////////////////////////////////

    // largest activation, value the neuron clips to
    localparam logic [ACTIVATION_WIDTH-1:0] ACT_MAX = {ACTIVATION_WIDTH{1'b1}};

endpackage

//--- rtl/nn_load_pkg.sv
package nn_load_pkg;

    import nn_fixed_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // load port layout
    ////////////////////////////////////////////////////////////////////////////

    // a weight word needs 26 bits, two spare at the top
    localparam int LOAD_WIDTH = 28;

    // neuron and index fields, up to 16 neurons
    localparam int NEURON_FIELD = 4;

    // layer field, up to 4 layers
    localparam int LAYER_FIELD = 2;

    localparam int WEIGHT_PAD = LOAD_WIDTH - LAYER_FIELD - 2 * NEURON_FIELD - WEIGHT_WIDTH;
    localparam int SAMPLE_PAD = LOAD_WIDTH - NEURON_FIELD - ACTIVATION_WIDTH;

    // selects the view of load_data
    typedef enum logic {
        LOAD_WEIGHT = 1'b0,
        LOAD_SAMPLE = 1'b1
    } load_kind_e;

    // weight view, value lands at (layer, index) of one neuron
    typedef struct packed {
        logic [WEIGHT_PAD-1:0]          pad;
        logic [LAYER_FIELD-1:0]         layer;
        logic [NEURON_FIELD-1:0]        neuron;
        logic [NEURON_FIELD-1:0]        index;
        logic signed [WEIGHT_WIDTH-1:0] value;
    } weight_load_s;

    // sample view, one element of the input vector
    typedef struct packed {
        logic [SAMPLE_PAD-1:0]       pad;
        logic [NEURON_FIELD-1:0]     index;
        logic [ACTIVATION_WIDTH-1:0] activation;
    } sample_load_s;

    typedef union packed {
        weight_load_s weight;
        sample_load_s sample;
    } load_word_u;

endpackage

//--- rtl/nn_top.sv
`timescale 1ns/100ps

module nn_top #(
    parameter int NEURON_NUM = 4,
    parameter int LAYER_MAX  = 2
) (
    input  logic                                                  clk,
    input  logic                                                  rst,
    input  logic                                                  load_valid,
    input  nn_load_pkg::load_kind_e                               load_kind,
    input  logic [nn_load_pkg::LOAD_WIDTH-1:0]                    load_data,
    input  logic                                                  start,
    output logic [NEURON_NUM-1:0][nn_fixed_pkg::ACTIVATION_WIDTH-1:0] result,
    output logic                                                  result_valid,
    input  logic                                                  result_ready,
    output logic                                                  overflow
);

    import nn_fixed_pkg::*;
    import nn_load_pkg::*;

    load_word_u                                  load_word;
    logic [LAYER_FIELD-1:0]                      layer;
    logic                                        layer_go;
    logic                                        run_start;
    logic                                        layer_done;
    logic [NEURON_NUM-1:0][ACTIVATION_WIDTH-1:0] layer_vector;
    logic [ACTIVATION_WIDTH-1:0]                 feed_act;
    logic [NEURON_FIELD-1:0]                     feed_index;
    logic                                        feed_valid;
    logic                                        feed_last;
    logic [NEURON_NUM-1:0][ACTIVATION_WIDTH-1:0] out_act;
    logic [NEURON_NUM-1:0]                       out_valid;
    logic [NEURON_NUM-1:0]                       out_sat;

    // raw host word, decoded per load_kind downstream
    assign load_word = load_data;

    // last layer output is the network result
    assign result = layer_vector;

    layer_sequencer #(
        .LAYER_MAX(LAYER_MAX)
    ) sequencer (
        .clk         (clk         ),
        .rst         (rst         ),
        .start       (start       ),
        .layer_done  (layer_done  ),
        .result_ready(result_ready),
        .layer       (layer       ),
        .layer_go    (layer_go    ),
        .run_start   (run_start   ),
        .result_valid(result_valid)
    );

    layer_feed #(
        .NEURON_NUM(NEURON_NUM)
    ) feed (
        .clk         (clk         ),
        .rst         (rst         ),
        .load_valid  (load_valid  ),
        .load_kind   (load_kind   ),
        .load_data   (load_word   ),
        .layer       (layer       ),
        .layer_go    (layer_go    ),
        .layer_vector(layer_vector),
        .feed_act    (feed_act    ),
        .feed_index  (feed_index  ),
        .feed_valid  (feed_valid  ),
        .feed_last   (feed_last   )
    );

    ////////////////////////////////////////////////////////////////////////////
    // neuron array, all share the feed broadcast
    ////////////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < NEURON_NUM; i++) begin : g_neuron
        neuron #(
            .NEURON_NUM  (NEURON_NUM),
            .LAYER_MAX   (LAYER_MAX ),
            .NEURON_INDEX(i         )
        ) neuron_i (
            .clk       (clk         ),
            .rst       (rst         ),
            .load_valid(load_valid  ),
            .load_kind (load_kind   ),
            .load_data (load_word   ),
            .layer     (layer       ),
            .layer_go  (layer_go    ),
            .feed_act  (feed_act    ),
            .feed_index(feed_index  ),
            .feed_valid(feed_valid  ),
            .feed_last (feed_last   ),
            .out_act   (out_act[i]  ),
            .out_valid (out_valid[i]),
            .out_sat   (out_sat[i]  )
        );
    end

    activation_collector #(
        .NEURON_NUM(NEURON_NUM)
    ) collector (
        .clk         (clk         ),
        .rst         (rst         ),
        .out_act     (out_act     ),
        .out_valid   (out_valid   ),
        .out_sat     (out_sat     ),
        .run_start   (run_start   ),
        .layer_vector(layer_vector),
        .layer_done  (layer_done  ),
        .overflow    (overflow    )
    );

endmodule
